// ==== hdl/vfdsu_defines.svh ====
`ifndef VFDSU_DEFINES_SVH
`define VFDSU_DEFINES_SVH

// ==============================
// srt round counter
// ==============================

// counter width, wide enough for the double start count
`define VFDSU_SRT_CNT_W 5

// start counts, loaded when ex1 pipes down
// double precision
`define VFDSU_SRT_CNT_DOUBLE 5'd13
// single precision
`define VFDSU_SRT_CNT_SINGLE 5'd6
// half precision, neither double nor single set
`define VFDSU_SRT_CNT_HALF 5'd3

// ==============================
// write-back state machine
// ==============================

// state register width
// bit 2 marks the busy states
`define VFDSU_DIV_ST_W 4

`endif

// ==== hdl/vfdsu_pkg.sv ====
`include "vfdsu_defines.svh"

package vfdsu_pkg;

  // ==============================
  // datapath side types
  // ==============================

  // operand precision
  // both bits clear means half
  typedef struct packed {
    logic double;
    logic single;
  } fdsu_prec_t;

  // srt status from the datapath, a level during ex2
  typedef struct packed {
    logic rem_zero;
    logic skip_srt;
  } srt_status_t;

  // srt iteration flags toward the datapath
  typedef struct packed {
    logic on;
    logic first_round;
    logic secd_round;
  } srt_round_t;

  // stage pipedown strobes
  typedef struct packed {
    logic ex1;
    logic ex2;
    logic ex3;
  } stage_strobe_t;

  // ==============================
  // write-back state encoding
  // ==============================

  // bit 2 set on rf, ex1, ex2 and wb_req
  typedef enum logic [`VFDSU_DIV_ST_W-1:0] {
    IDLE   = 4'b0000,
    RF     = 4'b0100,
    EX1    = 4'b0101,
    EX2    = 4'b0110,
    WB_REQ = 4'b0111,
    WB     = 4'b1000
  } div_state_e;

endpackage

// ==== hdl/srt_round_ctrl.sv ====
`include "vfdsu_defines.svh"

module srt_round_ctrl (
  input  logic                   srt_sm_clk,
  input  logic                   cpurst_b,
  input  logic                   flush,
  input  logic                   ex1_pipedown,
  input  vfdsu_pkg::fdsu_prec_t  ex1_prec,
  input  vfdsu_pkg::fdsu_prec_t  ex2_prec,
  input  vfdsu_pkg::srt_status_t srt_status,
  output vfdsu_pkg::srt_round_t  srt_round,
  output logic                   srt_last_round
);

  localparam int CW = `VFDSU_SRT_CNT_W;

  // two-state srt machine
  localparam logic SRT_IDLE = 1'b0;
  localparam logic SRT_BUSY = 1'b1;

  logic          srt_cur_state;
  logic          srt_nxt_state;
  logic          srt_sm_on;
  logic [CW-1:0] srt_cnt;
  logic [CW-1:0] srt_cnt_ini;
  logic          srt_cnt_zero;
  logic          secd_round_pre;
  logic          first_round_q;
  logic          secd_round_q;

  // start count per precision
  // double wins over single, half otherwise
  function automatic logic [CW-1:0] start_cnt(input vfdsu_pkg::fdsu_prec_t prec);
    logic [CW-1:0] cnt;
    if (prec.double)
      cnt = `VFDSU_SRT_CNT_DOUBLE;
    else if (prec.single)
      cnt = `VFDSU_SRT_CNT_SINGLE;
    else
      cnt = `VFDSU_SRT_CNT_HALF;
    return cnt;
  endfunction

  // ==============================
  // srt state machine
  // ==============================

  always_ff @(posedge srt_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      srt_cur_state <= SRT_IDLE;
    else if (flush)
      srt_cur_state <= SRT_IDLE;
    else
      srt_cur_state <= srt_nxt_state;
  end

  // leave idle on ex1 pipedown
  // back to idle on the last round
  always_comb
  begin
    case (srt_cur_state)
      SRT_IDLE:
      begin
        if (ex1_pipedown)
          srt_nxt_state = SRT_BUSY;
        else
          srt_nxt_state = SRT_IDLE;
      end
      SRT_BUSY:
      begin
        if (srt_last_round)
          srt_nxt_state = SRT_IDLE;
        else
          srt_nxt_state = SRT_BUSY;
      end
      default:
        srt_nxt_state = SRT_IDLE;
    endcase
  end

  assign srt_sm_on = (srt_cur_state == SRT_BUSY);

  // last round on any of three
  // counter run out, remainder zero, or no srt needed
  assign srt_cnt_zero   = ~|srt_cnt;
  assign srt_last_round = srt_sm_on &&
                          (srt_cnt_zero || srt_status.rem_zero || srt_status.skip_srt);

  // ==============================
  // round counter
  // ==============================

  assign srt_cnt_ini = start_cnt(ex1_prec);

  // load at ex1 pipedown, then one down per busy cycle
  always_ff @(posedge srt_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      srt_cnt <= '0;
    else if (flush)
      srt_cnt <= '0;
    else if (ex1_pipedown)
      srt_cnt <= srt_cnt_ini;
    else if (srt_sm_on)
      srt_cnt <= srt_cnt - CW'(1);
  end

  // ==============================
  // first and second round flags
  // ==============================

  // first round follows ex1 pipedown by one cycle
  always_ff @(posedge srt_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      first_round_q <= 1'b0;
    else if (flush)
      first_round_q <= 1'b0;
    else
      first_round_q <= ex1_pipedown;
  end

  // counter still at its start value means this is round one
  // no second round once round one was already the last
  assign secd_round_pre = srt_sm_on && !srt_last_round &&
                          (srt_cnt == start_cnt(ex2_prec));

  always_ff @(posedge srt_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      secd_round_q <= 1'b0;
    else if (flush)
      secd_round_q <= 1'b0;
    else
      secd_round_q <= secd_round_pre;
  end

  assign srt_round.on          = srt_sm_on;
  assign srt_round.first_round = first_round_q;
  assign srt_round.secd_round  = secd_round_q;

endmodule

// ==== hdl/div_wb_fsm.sv ====
module div_wb_fsm (
  input  logic srt_sm_clk,
  input  logic cpurst_b,
  input  logic flush,
  input  logic idu_fdiv_issue,
  input  logic ex1_pipedown,
  input  logic srt_last_round,
  input  logic ex2_pipedown,
  output logic div_st_ex2,
  output logic ex3_pipedown,
  output logic fdiv_busy,
  output logic inst_wb_req,
  output logic inst_vld,
  output logic debug_idle
);

  vfdsu_pkg::div_state_e div_cur_state;
  vfdsu_pkg::div_state_e div_next_state;

  logic ex3_vld;
  logic ex4_vld;

  // ==============================
  // ex2 to ex3 valid
  // ==============================

  // one-cycle valid behind the ex2 pipedown
  always_ff @(posedge srt_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex3_vld <= 1'b0;
    else if (flush)
      ex3_vld <= 1'b0;
    else
      ex3_vld <= ex2_pipedown;
  end

  assign ex3_pipedown = ex3_vld;

  // ==============================
  // ex3 to ex4 valid
  // ==============================

  always_ff @(posedge srt_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex4_vld <= 1'b0;
    else if (flush)
      ex4_vld <= 1'b0;
    else
      ex4_vld <= ex3_pipedown;
  end

  // ==============================
  // write-back state machine
  // ==============================

  always_ff @(posedge srt_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      div_cur_state <= vfdsu_pkg::IDLE;
    else if (flush)
      div_cur_state <= vfdsu_pkg::IDLE;
    else
      div_cur_state <= div_next_state;
  end

  always_comb
  begin
    div_next_state = div_cur_state;
    case (div_cur_state)
      // new issue only from idle or wb
      vfdsu_pkg::IDLE:
      begin
        if (idu_fdiv_issue)
          div_next_state = vfdsu_pkg::RF;
      end
      vfdsu_pkg::RF:
        div_next_state = vfdsu_pkg::EX1;
      // no pipex select, instruction dropped
      vfdsu_pkg::EX1:
      begin
        if (ex1_pipedown)
          div_next_state = vfdsu_pkg::EX2;
        else
          div_next_state = vfdsu_pkg::IDLE;
      end
      // srt iterations run here
      vfdsu_pkg::EX2:
      begin
        if (srt_last_round)
          div_next_state = vfdsu_pkg::WB_REQ;
      end
      // wait for the ex4 valid
      vfdsu_pkg::WB_REQ:
      begin
        if (ex4_vld)
          div_next_state = vfdsu_pkg::WB;
      end
      // back-to-back issue skips idle
      vfdsu_pkg::WB:
      begin
        if (idu_fdiv_issue)
          div_next_state = vfdsu_pkg::RF;
        else
          div_next_state = vfdsu_pkg::IDLE;
      end
      default:
        div_next_state = vfdsu_pkg::IDLE;
    endcase
  end

  // ==============================
  // status outputs
  // ==============================

  assign div_st_ex2  = (div_cur_state == vfdsu_pkg::EX2);
  // busy states share bit 2
  assign fdiv_busy   = div_cur_state[2];
  // request the write-back port one stage ahead
  assign inst_wb_req = ex3_vld;
  assign inst_vld    = (div_cur_state == vfdsu_pkg::WB);
  assign debug_idle  = (div_cur_state == vfdsu_pkg::IDLE);

endmodule

// ==== hdl/vfdsu_ctrl_top.sv ====
module vfdsu_ctrl_top (
  input  logic                     srt_sm_clk,
  input  logic                     cpurst_b,
  input  logic                     flush,
  input  logic                     idu_fdiv_issue,
  input  logic                     ex1_pipex_sel,
  input  vfdsu_pkg::fdsu_prec_t    ex1_prec,
  input  vfdsu_pkg::fdsu_prec_t    ex2_prec,
  input  vfdsu_pkg::srt_status_t   srt_status,
  output vfdsu_pkg::stage_strobe_t pipedown,
  output vfdsu_pkg::srt_round_t    srt_round,
  output logic                     fdiv_busy,
  output logic                     inst_wb_req,
  output logic                     inst_vld,
  output logic                     debug_idle
);

  logic ex1_pipedown;
  logic ex2_pipedown;
  logic ex3_pipedown;
  logic srt_last_round;
  logic div_st_ex2;

  // ==============================
  // stage strobes
  // ==============================

  // ex1 pipes down whenever the datapath selects it
  assign ex1_pipedown = ex1_pipex_sel;

  // ex2 done on the last srt round while in ex2
  assign ex2_pipedown = srt_last_round && div_st_ex2;

  assign pipedown = '{ex1: ex1_pipedown, ex2: ex2_pipedown, ex3: ex3_pipedown};

  // ==============================
  // controllers
  // ==============================

  // srt iteration control
  srt_round_ctrl u_srt (
    .srt_sm_clk     (srt_sm_clk),
    .cpurst_b       (cpurst_b),
    .flush          (flush),
    .ex1_pipedown   (ex1_pipedown),
    .ex1_prec       (ex1_prec),
    .ex2_prec       (ex2_prec),
    .srt_status     (srt_status),
    .srt_round      (srt_round),
    .srt_last_round (srt_last_round)
  );

  // stage valids and write-back sequencing
  div_wb_fsm u_wb (
    .srt_sm_clk     (srt_sm_clk),
    .cpurst_b       (cpurst_b),
    .flush          (flush),
    .idu_fdiv_issue (idu_fdiv_issue),
    .ex1_pipedown   (ex1_pipedown),
    .srt_last_round (srt_last_round),
    .ex2_pipedown   (ex2_pipedown),
    .div_st_ex2     (div_st_ex2),
    .ex3_pipedown   (ex3_pipedown),
    .fdiv_busy      (fdiv_busy),
    .inst_wb_req    (inst_wb_req),
    .inst_vld       (inst_vld),
    .debug_idle     (debug_idle)
  );

endmodule

// ==== dv/vfdsu_ctrl_checker.sv ====
module vfdsu_ctrl_checker (
  input logic                     srt_sm_clk,
  input logic                     cpurst_b,
  input logic                     flush,
  input vfdsu_pkg::stage_strobe_t pipedown,
  input vfdsu_pkg::srt_round_t    srt_round,
  input logic                     fdiv_busy,
  input logic                     inst_vld
);

  // failed assertions so far
  int fail_cnt = 0;

  // ==============================
  // write-back
  // ==============================

  // one write-back per instruction
  a_inst_vld_pulse: assert property (
    @(posedge srt_sm_clk) disable iff (!cpurst_b)
    inst_vld |=> !inst_vld
  ) else
  begin
    fail_cnt++;
    $error("inst_vld high for more than one cycle");
  end

  // ==============================
  // srt rounds
  // ==============================

  a_round_flags_apart: assert property (
    @(posedge srt_sm_clk) disable iff (!cpurst_b)
    !(srt_round.first_round && srt_round.secd_round)
  ) else
  begin
    fail_cnt++;
    $error("first_round and secd_round high together");
  end

  // ex2 ends only inside an srt round
  a_ex2_in_round: assert property (
    @(posedge srt_sm_clk) disable iff (!cpurst_b)
    pipedown.ex2 |-> srt_round.on
  ) else
  begin
    fail_cnt++;
    $error("pipedown.ex2 without srt_round.on");
  end

  // flush clears the busy states
  a_flush_clears_busy: assert property (
    @(posedge srt_sm_clk) disable iff (!cpurst_b)
    flush |=> !fdiv_busy
  ) else
  begin
    fail_cnt++;
    $error("fdiv_busy still high after flush");
  end

endmodule

// ==== dv/vfdsu_ctrl_tb.sv ====
`include "vfdsu_defines.svh"

module vfdsu_ctrl_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  localparam vfdsu_pkg::fdsu_prec_t PREC_DOUBLE = '{double: 1'b1, single: 1'b0};
  localparam vfdsu_pkg::fdsu_prec_t PREC_SINGLE = '{double: 1'b0, single: 1'b1};
  localparam vfdsu_pkg::fdsu_prec_t PREC_HALF   = '{double: 1'b0, single: 1'b0};

  // expected dut outputs for one cycle
  typedef struct packed {
    logic on;
    logic first_round;
    logic secd_round;
    logic pd_ex1;
    logic pd_ex2;
    logic pd_ex3;
    logic fdiv_busy;
    logic inst_wb_req;
    logic inst_vld;
    logic debug_idle;
  } exp_out_t;

  logic                     srt_sm_clk;
  logic                     cpurst_b;
  logic                     flush;
  logic                     idu_fdiv_issue;
  logic                     ex1_pipex_sel;
  vfdsu_pkg::fdsu_prec_t    ex1_prec;
  vfdsu_pkg::fdsu_prec_t    ex2_prec;
  vfdsu_pkg::srt_status_t   srt_status;
  vfdsu_pkg::stage_strobe_t pipedown;
  vfdsu_pkg::srt_round_t    srt_round;
  logic                     fdiv_busy;
  logic                     inst_wb_req;
  logic                     inst_vld;
  logic                     debug_idle;

  integer seed;
  int     cycle_cnt = 0;

  vfdsu_ctrl_top i_vfdsu_ctrl_top (
    .srt_sm_clk     (srt_sm_clk),
    .cpurst_b       (cpurst_b),
    .flush          (flush),
    .idu_fdiv_issue (idu_fdiv_issue),
    .ex1_pipex_sel  (ex1_pipex_sel),
    .ex1_prec       (ex1_prec),
    .ex2_prec       (ex2_prec),
    .srt_status     (srt_status),
    .pipedown       (pipedown),
    .srt_round      (srt_round),
    .fdiv_busy      (fdiv_busy),
    .inst_wb_req    (inst_wb_req),
    .inst_vld       (inst_vld),
    .debug_idle     (debug_idle)
  );

  bind vfdsu_ctrl_top vfdsu_ctrl_checker u_checker (
    .srt_sm_clk (srt_sm_clk),
    .cpurst_b   (cpurst_b),
    .flush      (flush),
    .pipedown   (pipedown),
    .srt_round  (srt_round),
    .fdiv_busy  (fdiv_busy),
    .inst_vld   (inst_vld)
  );

  // ==============================
  // clock and cycle limit
  // ==============================

  always #5 srt_sm_clk = ~srt_sm_clk;

  always @(posedge srt_sm_clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // assertion failures from the bound checker
  always @(negedge srt_sm_clk)
  begin
    if (i_vfdsu_ctrl_top.u_checker.fail_cnt != 0)
    begin
      $display("a checker assertion failed before cycle %0d", cycle_cnt);
      $display("STATUS: FAIL");
      $fatal(1, "checker assertion failed");
    end
  end

  // ==============================
  // compare helpers
  // ==============================

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("error: %s is %0h, expected %0h at cycle %0d", name, actual, expected,
               cycle_cnt);
      $display("STATUS: FAIL");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic check_outputs(input exp_out_t e);
    check_value("srt_round.on", srt_round.on, e.on);
    check_value("srt_round.first_round", srt_round.first_round, e.first_round);
    check_value("srt_round.secd_round", srt_round.secd_round, e.secd_round);
    check_value("pipedown.ex1", pipedown.ex1, e.pd_ex1);
    check_value("pipedown.ex2", pipedown.ex2, e.pd_ex2);
    check_value("pipedown.ex3", pipedown.ex3, e.pd_ex3);
    check_value("fdiv_busy", fdiv_busy, e.fdiv_busy);
    check_value("inst_wb_req", inst_wb_req, e.inst_wb_req);
    check_value("inst_vld", inst_vld, e.inst_vld);
    check_value("debug_idle", debug_idle, e.debug_idle);
  endtask

  // outputs k cycles after ex1 pipedown
  // last round at k == last
  function automatic exp_out_t expected_round(input int k, input int last);
    exp_out_t e;
    e = '0;
    e.on          = (k >= 1) && (k <= last);
    e.first_round = (k == 1);
    // no second round when round one already ended it
    e.secd_round  = (k == 2) && (last > 1);
    e.pd_ex2      = (k == last);
    e.pd_ex3      = (k == last + 1);
    e.inst_wb_req = (k == last + 1);
    // busy through wb_req
    // low once wb is reached
    e.fdiv_busy   = (k <= last + 2);
    e.inst_vld    = (k == last + 3);
    return e;
  endfunction

  // ==============================
  // stimulus steps
  // ==============================

  task automatic idle_cycle();
    exp_out_t e;
    @(posedge srt_sm_clk);
    idu_fdiv_issue <= 1'b0;
    ex1_pipex_sel  <= 1'b0;
    flush          <= 1'b0;
    srt_status     <= '0;
    @(negedge srt_sm_clk);
    e = '0;
    e.debug_idle = 1'b1;
    check_outputs(e);
  endtask

  // issue accepted only while not busy
  task automatic issue_cycle();
    @(posedge srt_sm_clk);
    idu_fdiv_issue <= 1'b1;
    @(negedge srt_sm_clk);
    check_value("fdiv_busy", fdiv_busy, 1'b0);
  endtask

  // rf cycle then ex1 with or without pipex select
  task automatic enter_ex1(input vfdsu_pkg::fdsu_prec_t prec, input logic sel);
    exp_out_t e;
    @(posedge srt_sm_clk);
    idu_fdiv_issue <= 1'b0;
    @(negedge srt_sm_clk);
    e = '0;
    e.fdiv_busy = 1'b1;
    check_outputs(e);
    @(posedge srt_sm_clk);
    ex1_pipex_sel <= sel;
    ex1_prec      <= prec;
    ex2_prec      <= prec;
    @(negedge srt_sm_clk);
    e.pd_ex1 = sel;
    check_outputs(e);
  endtask

  // runs from rf to wb
  // early_at 0 means full count
  task automatic run_division(input vfdsu_pkg::fdsu_prec_t prec, input int n,
                              input int early_at, input logic early_skip,
                              input logic issue_in_wb);
    vfdsu_pkg::srt_status_t st;
    int last;
    int k;
    last = (early_at != 0) ? early_at : n + 1;
    enter_ex1(prec, 1'b1);
    for (k = 1; k <= last + 3; k++)
    begin
      st.rem_zero = !early_skip && (k == early_at);
      st.skip_srt = early_skip && (k == early_at);
      @(posedge srt_sm_clk);
      ex1_pipex_sel  <= 1'b0;
      srt_status     <= st;
      idu_fdiv_issue <= issue_in_wb && (k == last + 3);
      @(negedge srt_sm_clk);
      check_outputs(expected_round(k, last));
    end
  endtask

  // ==============================
  // directed tests
  // ==============================

  task automatic check_reset_state();
    idle_cycle();
  endtask

  // on from T+1 to T+14 with ex2 at T+14
  // wb_req at T+15 and inst_vld at T+17
  task automatic run_double_division();
    issue_cycle();
    run_division(PREC_DOUBLE, `VFDSU_SRT_CNT_DOUBLE, 0, 1'b0, 1'b0);
    idle_cycle();
  endtask

  task automatic run_random_precision();
    logic [31:0] pick;
    int i;
    for (i = 0; i < 4; i++)
    begin
      pick = $random(seed);
      issue_cycle();
      if (pick[0])
        run_division(PREC_SINGLE, `VFDSU_SRT_CNT_SINGLE, 0, 1'b0, 1'b0);
      else
        run_division(PREC_HALF, `VFDSU_SRT_CNT_HALF, 0, 1'b0, 1'b0);
      idle_cycle();
    end
  endtask

  task automatic run_early_finish();
    // remainder zero in round four
    issue_cycle();
    run_division(PREC_DOUBLE, `VFDSU_SRT_CNT_DOUBLE, 4, 1'b0, 1'b0);
    idle_cycle();
    // skip in round one leaves no second round
    issue_cycle();
    run_division(PREC_SINGLE, `VFDSU_SRT_CNT_SINGLE, 1, 1'b1, 1'b0);
    idle_cycle();
  endtask

  task automatic drop_and_reissue();
    issue_cycle();
    // ex1 without pipex select falls back to idle at t+3
    enter_ex1(PREC_HALF, 1'b0);
    idle_cycle();
    // second issue in wb goes straight to rf
    issue_cycle();
    run_division(PREC_HALF, `VFDSU_SRT_CNT_HALF, 0, 1'b0, 1'b1);
    run_division(PREC_DOUBLE, `VFDSU_SRT_CNT_DOUBLE, 0, 1'b0, 1'b0);
    idle_cycle();
  endtask

  task automatic flush_mid_division();
    int k;
    issue_cycle();
    enter_ex1(PREC_DOUBLE, 1'b1);
    for (k = 1; k <= 4; k++)
    begin
      @(posedge srt_sm_clk);
      ex1_pipex_sel <= 1'b0;
      flush         <= (k == 4);
      @(negedge srt_sm_clk);
      check_outputs(expected_round(k, `VFDSU_SRT_CNT_DOUBLE + 1));
    end
    // everything clear one cycle after the flush
    idle_cycle();
    idle_cycle();
  endtask

  // ==============================
  // main sequence
  // ==============================

  initial
  begin
    seed           = 32'hdd6e;
    srt_sm_clk     = 1'b0;
    cpurst_b       = 1'b0;
    flush          = 1'b0;
    idu_fdiv_issue = 1'b0;
    ex1_pipex_sel  = 1'b0;
    ex1_prec       = '0;
    ex2_prec       = '0;
    srt_status     = '0;
    repeat (8) @(posedge srt_sm_clk);
    cpurst_b <= 1'b1;
    check_reset_state();
    run_double_division();
    run_random_precision();
    run_early_finish();
    drop_and_reissue();
    flush_mid_division();
    if (i_vfdsu_ctrl_top.u_checker.fail_cnt == 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
    begin
      $display("STATUS: FAIL");
      $fatal(1, "%0d checker assertions failed", i_vfdsu_ctrl_top.u_checker.fail_cnt);
    end
  end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/vfdsu_pkg.sv
hdl/srt_round_ctrl.sv
hdl/div_wb_fsm.sv
hdl/vfdsu_ctrl_top.sv
dv/vfdsu_ctrl_checker.sv
dv/vfdsu_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: vfdsu_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vfdsu_pkg.sv
      - hdl/srt_round_ctrl.sv
      - hdl/div_wb_fsm.sv
      - hdl/vfdsu_ctrl_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/vfdsu_ctrl_checker.sv
      - dv/vfdsu_ctrl_tb.sv
